// File: common/mem_test_params.svh
`ifndef MEM_TEST_PARAMS_SVH
`define MEM_TEST_PARAMS_SVH

// Width of one memory word
`define MT_DATA_W 256

// Word address width toward the memory
`define MT_ADDR_W 28

// Entries per pass, also the depth of the memory model
`define MT_MAX_ENTRIES 16

// Cycles from the first cycle of mem_valid to mem_ready
`define MT_MEM_LATENCY 3

`endif

// File: common/mem_test_pkg.sv
`default_nettype none

`include "mem_test_params.svh"

package mem_test_pkg;

	typedef logic [`MT_DATA_W-1:0] data_t;
	typedef logic [`MT_ADDR_W-1:0] addr_t;

	// Register map, one 32-bit word per index
	typedef enum logic [3:0]
	{
		REG_CTRL       = 4'd0,
		REG_ENTRIES    = 4'd1,
		REG_PASSES     = 4'd2,
		REG_GAP        = 4'd3,
		REG_BASE       = 4'd4,
		REG_SEED       = 4'd5,
		REG_FAULT_IDX  = 4'd6,
		REG_STATUS     = 4'd8,
		REG_PASS_DONE  = 4'd9,
		REG_FAIL_COUNT = 4'd10,
		REG_FIRST_FAIL = 4'd11
	} reg_idx_e;

	// Traffic generator sequencing
	typedef enum logic [2:0]
	{
		IDLE,
		WRITE,
		READ,
		GAP,
		DONE
	} gen_state_e;

endpackage

`default_nettype wire

// File: traffic_gen/pattern_rom.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_test_params.svh"

module pattern_rom
(
	input  wire [31:0]               seed,
	input  wire [7:0]                idx,
	output mem_test_pkg::data_t      pattern
);

	mem_test_pkg::data_t base_word;
	mem_test_pkg::data_t mixed;

	////////////////////////////////////////////////////////////
	// Base words, one per low index value
	////////////////////////////////////////////////////////////
	always_comb
	begin
		case (idx[2:0])
			3'd0: base_word = {4{64'h00000000_FFFFFFFF}};
			3'd1: base_word = {4{64'hAAAAAAAA_55555555}};
			3'd2: base_word = {4{64'h33333333_CCCCCCCC}};
			3'd3: base_word = {4{64'h0F0F0F0F_F0F0F0F0}};
			3'd4: base_word = {4{64'h00FF00FF_FF00FF00}};
			3'd5: base_word = {4{64'h0000FFFF_FFFF0000}};
			3'd6: base_word = {2{128'h01234567_89ABCDEF_FEDCBA98_76543210}};
			default: base_word = {128'h80000001_40000002_20000004_10000008,
				128'h08000010_04000020_02000040_01000080};
		endcase
	end

	// Seed spread over all eight lanes
	assign mixed = base_word ^ {8{seed}};

	// Index in the low byte keeps entries 0..7 apart from 8..15
	assign pattern = {mixed[`MT_DATA_W-1:8], mixed[7:0] + idx};

endmodule

`default_nettype wire

// File: traffic_gen/traffic_gen.sv
`timescale 1ns/1ps
`default_nettype none

module traffic_gen
(
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      start,
	input  wire [7:0]                entries,
	input  wire [7:0]                passes,
	input  wire [7:0]                gap,
	input  wire mem_test_pkg::addr_t base_addr,
	output logic [7:0]               pattern_idx,
	input  wire mem_test_pkg::data_t pattern,
	output logic                     mem_valid,
	output logic                     mem_rw,
	output mem_test_pkg::addr_t      mem_addr,
	output mem_test_pkg::data_t      mem_wdata,
	input  wire                      mem_ready,
	output logic                     busy,
	output logic                     done,
	output logic [7:0]               pass_done
);

	mem_test_pkg::gen_state_e state;
	logic [7:0] entry_cnt;
	logic [7:0] gap_cnt;
	logic [7:0] next_idx;
	logic       last_entry;
	logic       last_pass;
	logic       launch;
	logic       wr_done;

	assign last_entry = (entry_cnt == entries - 8'd1);
	assign last_pass  = (pass_done == passes - 8'd1);
	assign next_idx   = last_entry ? 8'd0 : entry_cnt + 8'd1;
	assign launch     = (state == mem_test_pkg::IDLE || state == mem_test_pkg::DONE) && start;
	assign wr_done    = (state == mem_test_pkg::WRITE) && mem_ready;

	// While a write is out, the table already looks at the next entry
	assign pattern_idx = (state == mem_test_pkg::WRITE) ? next_idx : entry_cnt;

	////////////////////////////////////////////////////////////
	// Command sequencer
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state     <= mem_test_pkg::IDLE;
			mem_valid <= 1'b0;
			mem_rw    <= 1'b0;
			mem_addr  <= '0;
			busy      <= 1'b0;
			done      <= 1'b0;
			entry_cnt <= 8'd0;
			gap_cnt   <= 8'd0;
			pass_done <= 8'd0;
		end
		else
		begin
			case (state)
				mem_test_pkg::IDLE, mem_test_pkg::DONE:
				begin
					if (start)
					begin
						done      <= 1'b0;
						pass_done <= 8'd0;
						entry_cnt <= 8'd0;
						// Nothing to run, finish at once
						if (entries == 8'd0 || passes == 8'd0)
						begin
							state <= mem_test_pkg::DONE;
							done  <= 1'b1;
						end
						else
						begin
							state     <= mem_test_pkg::WRITE;
							busy      <= 1'b1;
							mem_valid <= 1'b1;
							mem_rw    <= 1'b1;
							mem_addr  <= base_addr;
						end
					end
				end
				mem_test_pkg::WRITE:
				begin
					// Read back the same address
					if (mem_ready)
					begin
						mem_rw <= 1'b0;
						if (gap == 8'd0)
							state <= mem_test_pkg::READ;
						else
						begin
							mem_valid <= 1'b0;
							gap_cnt   <= gap;
							state     <= mem_test_pkg::GAP;
						end
					end
				end
				mem_test_pkg::READ:
				begin
					if (mem_ready)
					begin
						entry_cnt <= next_idx;
						if (last_entry)
							pass_done <= pass_done + 8'd1;
						if (last_entry && last_pass)
						begin
							state     <= mem_test_pkg::DONE;
							mem_valid <= 1'b0;
							busy      <= 1'b0;
							done      <= 1'b1;
						end
						else
						begin
							mem_rw   <= 1'b1;
							mem_addr <= base_addr + mem_test_pkg::addr_t'(next_idx);
							if (gap == 8'd0)
								state <= mem_test_pkg::WRITE;
							else
							begin
								mem_valid <= 1'b0;
								gap_cnt   <= gap;
								state     <= mem_test_pkg::GAP;
							end
						end
					end
				end
				mem_test_pkg::GAP:
				begin
					// mem_rw already holds the kind of the next command
					if (gap_cnt == 8'd1)
					begin
						mem_valid <= 1'b1;
						state     <= mem_rw ? mem_test_pkg::WRITE : mem_test_pkg::READ;
					end
					else
						gap_cnt <= gap_cnt - 8'd1;
				end
				default:
					state <= mem_test_pkg::IDLE;
			endcase
		end
	end

	// Write data for entry 0 at launch, then the next entry on each write completion
	always_ff @(posedge clk)
	begin
		if (launch || wr_done)
			mem_wdata <= pattern;
	end

	cmd_stable_a: assert property (@(posedge clk) disable iff (rst)
		mem_valid && !mem_ready |=> mem_valid && $stable(mem_rw) && $stable(mem_addr))
		else $error("traffic_gen: command changed before mem_ready");

	idle_quiet_a: assert property (@(posedge clk) disable iff (rst)
		state == mem_test_pkg::IDLE |-> !mem_valid)
		else $error("traffic_gen: mem_valid high in IDLE");

endmodule

`default_nettype wire

// File: traffic_gen/read_checker.sv
`timescale 1ns/1ps
`default_nettype none

module read_checker
(
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      clear,
	input  wire                      rd_done,
	input  wire mem_test_pkg::data_t rd_data,
	input  wire mem_test_pkg::data_t expected,
	input  wire [7:0]                idx,
	output logic                     error,
	output logic [15:0]              fail_count,
	output logic [7:0]               first_fail
);

	logic mismatch;

	assign mismatch = rd_done && (rd_data != expected);

	////////////////////////////////////////////////////////////
	// Sticky result registers
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst || clear)
		begin
			error      <= 1'b0;
			fail_count <= 16'd0;
			first_fail <= 8'd0;
		end
		else if (mismatch)
		begin
			error <= 1'b1;
			// Saturates instead of wrapping back to zero
			if (fail_count != 16'hFFFF)
				fail_count <= fail_count + 16'd1;
			// Only the earliest failing entry is kept
			if (!error)
				first_fail <= idx;
		end
	end

	// A clear always lands on a cycle with no read completing
	clear_quiet_a: assert property (@(posedge clk) disable iff (rst)
		clear |-> !rd_done)
		else $error("read_checker: clear during a read completion");

endmodule

`default_nettype wire

// File: rtl/test_ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_test_params.svh"

module test_ctrl_regs
(
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  reg_wr,
	input  wire                  reg_rd,
	input  wire [3:0]            reg_addr,
	input  wire [31:0]           reg_wdata,
	output logic [31:0]          reg_rdata,
	output logic                 start,
	output logic [7:0]           entries,
	output logic [7:0]           passes,
	output logic [7:0]           gap,
	output mem_test_pkg::addr_t  base_addr,
	output logic [31:0]          seed,
	output logic                 fault_en,
	output logic [7:0]           fault_idx,
	input  wire                  busy,
	input  wire                  done,
	input  wire                  error,
	input  wire [7:0]            pass_done,
	input  wire [15:0]           fail_count,
	input  wire [7:0]            first_fail
);

	logic start_req;

	// CTRL bit 0, dropped while a run is active
	assign start_req = reg_wr && (reg_addr == mem_test_pkg::REG_CTRL) && reg_wdata[0];

	////////////////////////////////////////////////////////////
	// Configuration writes
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			start     <= 1'b0;
			entries   <= 8'd0;
			passes    <= 8'd0;
			gap       <= 8'd0;
			base_addr <= '0;
			seed      <= 32'd0;
			fault_en  <= 1'b0;
			fault_idx <= 8'd0;
		end
		else
		begin
			start <= start_req && !busy && !start;
			if (reg_wr)
			begin
				case (mem_test_pkg::reg_idx_e'(reg_addr))
					mem_test_pkg::REG_CTRL:      fault_en  <= reg_wdata[1];
					mem_test_pkg::REG_ENTRIES:   entries   <= reg_wdata[7:0];
					mem_test_pkg::REG_PASSES:    passes    <= reg_wdata[7:0];
					mem_test_pkg::REG_GAP:       gap       <= reg_wdata[7:0];
					mem_test_pkg::REG_BASE:      base_addr <= reg_wdata[`MT_ADDR_W-1:0];
					mem_test_pkg::REG_SEED:      seed      <= reg_wdata;
					mem_test_pkg::REG_FAULT_IDX: fault_idx <= reg_wdata[7:0];
					default: ;
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Registered read back
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
			reg_rdata <= 32'd0;
		else if (reg_rd)
		begin
			case (mem_test_pkg::reg_idx_e'(reg_addr))
				mem_test_pkg::REG_CTRL:       reg_rdata <= {30'd0, fault_en, 1'b0};
				mem_test_pkg::REG_ENTRIES:    reg_rdata <= {24'd0, entries};
				mem_test_pkg::REG_PASSES:     reg_rdata <= {24'd0, passes};
				mem_test_pkg::REG_GAP:        reg_rdata <= {24'd0, gap};
				mem_test_pkg::REG_BASE:       reg_rdata <= {{(32-`MT_ADDR_W){1'b0}}, base_addr};
				mem_test_pkg::REG_SEED:       reg_rdata <= seed;
				mem_test_pkg::REG_FAULT_IDX:  reg_rdata <= {24'd0, fault_idx};
				mem_test_pkg::REG_STATUS:     reg_rdata <= {29'd0, error, done, busy};
				mem_test_pkg::REG_PASS_DONE:  reg_rdata <= {24'd0, pass_done};
				mem_test_pkg::REG_FAIL_COUNT: reg_rdata <= {16'd0, fail_count};
				mem_test_pkg::REG_FIRST_FAIL: reg_rdata <= {24'd0, first_fail};
				default:                      reg_rdata <= 32'd0;
			endcase
		end
	end

	start_pulse_a: assert property (@(posedge clk) disable iff (rst) start |=> !start)
		else $error("test_ctrl_regs: start held for two cycles");

endmodule

`default_nettype wire

// File: rtl/mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_test_params.svh"

module mem_model
(
	input  wire                      clk,
	input  wire                      rst,
	input  wire                      mem_valid,
	input  wire                      mem_rw,
	input  wire mem_test_pkg::addr_t mem_addr,
	input  wire mem_test_pkg::data_t mem_wdata,
	output logic                     mem_ready,
	output mem_test_pkg::data_t      mem_rdata,
	input  wire                      fault_en,
	input  wire [7:0]                fault_idx,
	input  wire mem_test_pkg::addr_t base_addr
);

	localparam int IDX_W = $clog2(`MT_MAX_ENTRIES);
	localparam int CNT_W = $clog2(`MT_MEM_LATENCY + 1);

	mem_test_pkg::data_t mem [`MT_MAX_ENTRIES];
	mem_test_pkg::addr_t fault_addr;
	logic [IDX_W-1:0]    word_idx;
	logic [CNT_W-1:0]    lat_cnt;
	logic                fault_hit;
	logic                complete;

	assign word_idx   = mem_addr[IDX_W-1:0];
	assign fault_addr = base_addr + mem_test_pkg::addr_t'(fault_idx);
	assign fault_hit  = fault_en && (mem_addr == fault_addr);

	// Last counted cycle before mem_ready
	assign complete = mem_valid && !mem_ready && (lat_cnt == CNT_W'(`MT_MEM_LATENCY - 1));

	////////////////////////////////////////////////////////////
	// Latency pacing
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			mem_ready <= 1'b0;
			lat_cnt   <= '0;
		end
		else if (mem_ready)
			mem_ready <= 1'b0;
		else if (complete)
		begin
			mem_ready <= 1'b1;
			lat_cnt   <= '0;
		end
		else if (mem_valid)
			lat_cnt <= lat_cnt + 1'b1;
	end

	// Storage, with bit 0 flipped on the faulty entry
	always_ff @(posedge clk)
	begin
		if (complete)
		begin
			if (mem_rw)
				mem[word_idx] <= fault_hit ? {mem_wdata[`MT_DATA_W-1:1], ~mem_wdata[0]} : mem_wdata;
			else
				mem_rdata <= mem[word_idx];
		end
	end

	ready_needs_valid_a: assert property (@(posedge clk) disable iff (rst)
		mem_ready |-> mem_valid)
		else $error("mem_model: mem_ready without mem_valid");

endmodule

`default_nettype wire

// File: rtl/mem_test_top.sv
`timescale 1ns/1ps
`default_nettype none

module mem_test_top
(
	input  wire        clk,
	input  wire        rst,
	input  wire        reg_wr,
	input  wire        reg_rd,
	input  wire [3:0]  reg_addr,
	input  wire [31:0] reg_wdata,
	output logic [31:0] reg_rdata
);

	// Register block outputs
	logic                start;
	logic [7:0]          entries;
	logic [7:0]          passes;
	logic [7:0]          gap;
	mem_test_pkg::addr_t base_addr;
	logic [31:0]         seed;
	logic                fault_en;
	logic [7:0]          fault_idx;

	// Status back to the registers
	logic                busy;
	logic                done;
	logic                error;
	logic [7:0]          pass_done;
	logic [15:0]         fail_count;
	logic [7:0]          first_fail;

	// Generator, pattern table and memory
	logic [7:0]          pattern_idx;
	mem_test_pkg::data_t pattern;
	logic                mem_valid;
	logic                mem_rw;
	logic                mem_ready;
	mem_test_pkg::addr_t mem_addr;
	mem_test_pkg::data_t mem_wdata;
	mem_test_pkg::data_t mem_rdata;

	test_ctrl_regs u_regs (
		.clk(clk), .rst(rst),
		.reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
		.reg_wdata(reg_wdata), .reg_rdata(reg_rdata),
		.start(start), .entries(entries), .passes(passes), .gap(gap),
		.base_addr(base_addr), .seed(seed), .fault_en(fault_en), .fault_idx(fault_idx),
		.busy(busy), .done(done), .error(error), .pass_done(pass_done),
		.fail_count(fail_count), .first_fail(first_fail)
	);

	traffic_gen u_gen (
		.clk(clk), .rst(rst), .start(start),
		.entries(entries), .passes(passes), .gap(gap), .base_addr(base_addr),
		.pattern_idx(pattern_idx), .pattern(pattern),
		.mem_valid(mem_valid), .mem_rw(mem_rw), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ready(mem_ready),
		.busy(busy), .done(done), .pass_done(pass_done)
	);

	pattern_rom u_rom (
		.seed(seed), .idx(pattern_idx), .pattern(pattern)
	);

	// Expected word and index follow the generator's current entry
	read_checker u_checker (
		.clk(clk), .rst(rst), .clear(start),
		.rd_done(mem_ready && !mem_rw), .rd_data(mem_rdata),
		.expected(pattern), .idx(pattern_idx),
		.error(error), .fail_count(fail_count), .first_fail(first_fail)
	);

	mem_model u_mem (
		.clk(clk), .rst(rst),
		.mem_valid(mem_valid), .mem_rw(mem_rw), .mem_addr(mem_addr),
		.mem_wdata(mem_wdata), .mem_ready(mem_ready), .mem_rdata(mem_rdata),
		.fault_en(fault_en), .fault_idx(fault_idx), .base_addr(base_addr)
	);

endmodule

`default_nettype wire

// File: verification/tb_mem_test.sv
`timescale 1ns/1ps
`default_nettype none

`include "mem_test_params.svh"

module tb_mem_test;

	localparam int CLK_HALF = 4;

	logic        clk;
	logic        rst;
	logic        reg_wr;
	logic        reg_rd;
	logic [3:0]  reg_addr;
	logic [31:0] reg_wdata;
	wire  [31:0] reg_rdata;

	// One register value under comparison
	logic        check_req;
	logic [31:0] check_actual;
	logic [31:0] check_expected;
	string       check_name;

	// STATUS samples taken while waiting for done
	logic        poll_active;
	logic [31:0] poll_status;

	int          seed_var;
	int          err_cnt;
	int          test_err_base;
	int          tests_passed;
	int          tests_failed;
	int          timeout_cycles;
	logic        budget_ready = 1'b0;

	logic [31:0] multi_seed;
	logic [31:0] multi_base;
	int          multi_gap;
	logic [31:0] fault_seed;
	logic [31:0] fault_base;

	mem_test_top u_mem_test_top (
		.clk(clk), .rst(rst),
		.reg_wr(reg_wr), .reg_rd(reg_rd), .reg_addr(reg_addr),
		.reg_wdata(reg_wdata), .reg_rdata(reg_rdata)
	);

	always #(CLK_HALF) clk = ~clk;

	////////////////////////////////////////////////////////////
	// Checks on register reads
	////////////////////////////////////////////////////////////
	reg_value_a: assert property (@(posedge clk) disable iff (rst)
		check_req |-> check_actual == check_expected)
		else
		begin
			$display("[FAIL] %0d ns %s expected 0x%08h actual 0x%08h",
				$time, check_name, check_expected, check_actual);
			err_cnt++;
		end

	// busy and done never show together
	done_while_busy_a: assert property (@(posedge clk) disable iff (rst)
		poll_active |-> !(poll_status[0] && poll_status[1]))
		else
		begin
			$display("[FAIL] %0d ns STATUS.done expected 0 actual 1 while busy", $time);
			err_cnt++;
		end

	////////////////////////////////////////////////////////////
	// Register port tasks
	////////////////////////////////////////////////////////////
	task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
		@(negedge clk);
		reg_wr    = 1'b1;
		reg_addr  = addr;
		reg_wdata = data;
		@(negedge clk);
		reg_wr = 1'b0;
	endtask

	task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
		@(negedge clk);
		reg_rd   = 1'b1;
		reg_addr = addr;
		@(negedge clk);
		reg_rd = 1'b0;
		data   = reg_rdata;
	endtask

	task automatic check_reg(input logic [3:0] addr, input logic [31:0] expected,
		input string name);
		logic [31:0] value;
		reg_read(addr, value);
		check_actual   = value;
		check_expected = expected;
		check_name     = name;
		check_req      = 1'b1;
		@(negedge clk);
		check_req = 1'b0;
	endtask

	task automatic configure(input int entries, input int passes, input int gap,
		input logic [31:0] base, input logic [31:0] seed, input int fault_idx);
		reg_write(mem_test_pkg::REG_ENTRIES, entries);
		reg_write(mem_test_pkg::REG_PASSES, passes);
		reg_write(mem_test_pkg::REG_GAP, gap);
		reg_write(mem_test_pkg::REG_BASE, base);
		reg_write(mem_test_pkg::REG_SEED, seed);
		reg_write(mem_test_pkg::REG_FAULT_IDX, fault_idx);
	endtask

	task automatic start_run(input logic fault_en);
		reg_write(mem_test_pkg::REG_CTRL, {30'd0, fault_en, 1'b1});
	endtask

	// Polls STATUS until done is set
	task automatic wait_done();
		logic [31:0] status;
		status      = 32'd0;
		poll_status = 32'd0;
		poll_active = 1'b1;
		while (!status[1])
		begin
			reg_read(mem_test_pkg::REG_STATUS, status);
			poll_status = status;
		end
		poll_active = 1'b0;
	endtask

	// Polls FAIL_COUNT until the first mismatch is counted
	task automatic wait_first_mismatch();
		logic [31:0] count;
		count = 32'd0;
		while (count == 32'd0)
			reg_read(mem_test_pkg::REG_FAIL_COUNT, count);
	endtask

	task automatic begin_test();
		test_err_base = err_cnt;
	endtask

	task automatic end_test(input string name);
		if (err_cnt == test_err_base)
		begin
			tests_passed++;
			$display("Test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("Test %s: %0d error(s)", name, err_cnt - test_err_base);
		end
	endtask

	// Cycles allowed for one scenario
	function automatic int run_budget(input int entries, input int passes, input int gap);
		return entries * passes * 2 * (`MT_MEM_LATENCY + gap + 2) + 100;
	endfunction

	////////////////////////////////////////////////////////////
	// Watchdog
	////////////////////////////////////////////////////////////
	initial
	begin
		wait (budget_ready);
		repeat (timeout_cycles) @(posedge clk);
		$display("Run timed out after %0d cycles", timeout_cycles);
		$display("Checks failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// Scenarios
	////////////////////////////////////////////////////////////
	initial
	begin
		clk            = 1'b0;
		rst            = 1'b1;
		reg_wr         = 1'b0;
		reg_rd         = 1'b0;
		reg_addr       = 4'd0;
		reg_wdata      = 32'd0;
		check_req      = 1'b0;
		check_actual   = 32'd0;
		check_expected = 32'd0;
		check_name     = "";
		poll_active    = 1'b0;
		poll_status    = 32'd0;
		err_cnt        = 0;
		test_err_base  = 0;
		tests_passed   = 0;
		tests_failed   = 0;

		seed_var   = 21721;
		multi_seed = $random(seed_var);
		multi_base = $random(seed_var);
		multi_base[31:`MT_ADDR_W] = '0;
		multi_gap  = $unsigned($random(seed_var)) % 8;
		fault_seed = $random(seed_var);
		fault_base = $random(seed_var);
		fault_base[31:`MT_ADDR_W] = '0;

		timeout_cycles = run_budget(0, 0, 0) + run_budget(8, 1, 0)
			+ run_budget(16, 3, multi_gap) + run_budget(8, 2, 1)
			+ run_budget(8, 1, 2) + run_budget(4, 2, 3);
		budget_ready = 1'b1;

		repeat (4) @(negedge clk);
		rst = 1'b0;

		begin_test();
		check_reg(mem_test_pkg::REG_STATUS, 32'd0, "STATUS");
		check_reg(mem_test_pkg::REG_PASS_DONE, 32'd0, "PASS_DONE");
		check_reg(mem_test_pkg::REG_FAIL_COUNT, 32'd0, "FAIL_COUNT");
		check_reg(mem_test_pkg::REG_FIRST_FAIL, 32'd0, "FIRST_FAIL");
		end_test("reset_values");

		// Single pass, back to back commands
		begin_test();
		configure(8, 1, 0, 32'h0000_0100, 32'h1234_5678, 0);
		start_run(1'b0);
		wait_done();
		check_reg(mem_test_pkg::REG_STATUS, 32'h2, "STATUS");
		check_reg(mem_test_pkg::REG_PASS_DONE, 32'd1, "PASS_DONE");
		check_reg(mem_test_pkg::REG_FAIL_COUNT, 32'd0, "FAIL_COUNT");
		end_test("clean_run");

		begin_test();
		configure(16, 3, multi_gap, multi_base, multi_seed, 0);
		start_run(1'b0);
		wait_done();
		check_reg(mem_test_pkg::REG_STATUS, 32'h2, "STATUS");
		check_reg(mem_test_pkg::REG_PASS_DONE, 32'd3, "PASS_DONE");
		check_reg(mem_test_pkg::REG_FAIL_COUNT, 32'd0, "FAIL_COUNT");
		end_test("multi_pass");

		// Entry 5 corrupted on every pass
		begin_test();
		configure(8, 2, 1, fault_base, fault_seed, 5);
		start_run(1'b1);
		wait_done();
		check_reg(mem_test_pkg::REG_STATUS, 32'h6, "STATUS");
		check_reg(mem_test_pkg::REG_PASS_DONE, 32'd2, "PASS_DONE");
		check_reg(mem_test_pkg::REG_FAIL_COUNT, 32'd2, "FAIL_COUNT");
		check_reg(mem_test_pkg::REG_FIRST_FAIL, 32'd5, "FIRST_FAIL");
		end_test("fault_inject");

		begin_test();
		configure(8, 1, 2, fault_base, fault_seed, 5);
		start_run(1'b0);
		wait_done();
		check_reg(mem_test_pkg::REG_STATUS, 32'h2, "STATUS");
		check_reg(mem_test_pkg::REG_FAIL_COUNT, 32'd0, "FAIL_COUNT");
		check_reg(mem_test_pkg::REG_FIRST_FAIL, 32'd0, "FIRST_FAIL");
		end_test("clear_on_start");

		// Second start lands mid run after the first mismatch of entry 0
		begin_test();
		configure(4, 2, 3, 32'h0000_0040, 32'hC0FF_EE00, 0);
		start_run(1'b1);
		check_reg(mem_test_pkg::REG_STATUS, 32'h1, "STATUS");
		wait_first_mismatch();
		start_run(1'b1);
		wait_done();
		check_reg(mem_test_pkg::REG_STATUS, 32'h6, "STATUS");
		check_reg(mem_test_pkg::REG_PASS_DONE, 32'd2, "PASS_DONE");
		check_reg(mem_test_pkg::REG_FAIL_COUNT, 32'd2, "FAIL_COUNT");
		end_test("start_while_busy");

		$display("Tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && err_cnt == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
+incdir+common
common/mem_test_pkg.sv
traffic_gen/pattern_rom.sv
traffic_gen/traffic_gen.sv
traffic_gen/read_checker.sv
rtl/test_ctrl_regs.sv
rtl/mem_model.sv
rtl/mem_test_top.sv
verification/tb_mem_test.sv

// File: Makefile
TOOL       := verilator
TOP        := tb_mem_test
FILELIST   := src.f
LINT_FLAGS := --lint-only -Wall --timing
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := Checks failed
PASS_MSG   := All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation gave no result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
